// File: logic/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer #(
    parameter int IMEM_ID_W = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  is_mem,
    input  logic                  pc_busy,
    input  rv_fetch_pkg::ex_rsp_t ex_rsp,
    input  logic                  cpu_ready,
    output logic                  if_valid,
    output logic [IMEM_ID_W-1:0]  if_send_id
);

    typedef enum logic [2:0] {
        st_idle,
        st_next,
        st_nmem,
        st_mem,
        st_write,
        st_next2,
        st_en,
        st_fn
    } seq_state_t;

    localparam logic [IMEM_ID_W-1:0] send_id = IMEM_ID_W'(rv_fetch_pkg::fetch_id);

    seq_state_t state;
    seq_state_t state_nx;
    logic       mem_seen;
    logic       wb_seen;
    logic       mem_hit;
    logic       wb_hit;

    assign mem_hit = ex_rsp.mem_res_valid | mem_seen;
    assign wb_hit  = ex_rsp.wb_res_valid | wb_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nx;
        end
    end

    // execute may answer before the phase machine gets to mem/write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_seen <= 1'b0;
            wb_seen  <= 1'b0;
        end else if (state == st_next2) begin
            mem_seen <= 1'b0;   // new fetch, drop old results
            wb_seen  <= 1'b0;
        end else begin
            if (ex_rsp.mem_res_valid) begin
                mem_seen <= 1'b1;
            end
            if (ex_rsp.wb_res_valid) begin
                wb_seen <= 1'b1;
            end
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            st_idle: begin
                if (is_mem) begin
                    state_nx = st_mem;
                end else begin
                    state_nx = st_next;
                end
            end
            st_next: begin
                if (ex_rsp.w_start) begin
                    state_nx = st_write;
                end else if (is_mem) begin
                    state_nx = st_mem;
                end else begin
                    state_nx = st_nmem;
                end
            end
            st_nmem: begin
                if (is_mem) begin
                    state_nx = st_mem;
                end else if (!pc_busy) begin   // pc settled for this instruction
                    state_nx = st_next2;
                end
            end
            st_mem: begin
                if (mem_hit) begin
                    state_nx = st_write;
                end
            end
            st_write: begin
                if (wb_hit && !pc_busy) begin
                    state_nx = st_next2;
                end
            end
            st_next2: state_nx = st_en;
            st_en: begin
                if (cpu_ready) begin
                    state_nx = st_fn;
                end
            end
            st_fn:   state_nx = st_idle;
            default: state_nx = st_idle;
        endcase
    end

    assign if_valid   = (state == st_next2);
    assign if_send_id = (state == st_next2 || state == st_en) ? send_id : '0;

endmodule

// File: logic/imem_read_port.sv
`timescale 1ns/1ps

module imem_read_port #(
    parameter int IMEM_ID_W = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               if_valid,
    input  logic [IMEM_ID_W-1:0]               if_send_id,
    input  logic [rv_fetch_pkg::cpu_width-1:0] curr_pc,
    output rv_fetch_pkg::imem_req_t            imem_req,
    input  rv_fetch_pkg::imem_rsp_t            imem_rsp,
    output rv_fetch_pkg::inst_u                word,
    output logic                               cpu_ready
);

    logic                               ar_valid_q;
    logic [rv_fetch_pkg::cpu_width-1:0] ar_addr_q;
    rv_fetch_pkg::imem_id_t             ar_id_q;
    logic                               rd_pend;
    logic                               rsp_hit;

    // only our own id, and only while a read is out
    assign rsp_hit = imem_rsp.r_valid && (rd_pend || ar_valid_q) &&
                     (imem_rsp.r_id == rv_fetch_pkg::fetch_id);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid_q <= 1'b0;
            rd_pend    <= 1'b0;
            cpu_ready  <= 1'b0;
        end else begin
            ar_valid_q <= if_valid;
            rd_pend    <= (rd_pend | ar_valid_q) & ~rsp_hit;
            cpu_ready  <= rsp_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid) begin
            ar_addr_q <= curr_pc;
            ar_id_q   <= rv_fetch_pkg::imem_id_t'(if_send_id);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word <= '0;   // zero word decodes to no class
        end else if (rsp_hit) begin
            word <= imem_rsp.r_data;
        end
    end

    assign imem_req.ar_valid = ar_valid_q;
    assign imem_req.ar_addr  = ar_addr_q;
    assign imem_req.ar_id    = ar_id_q;

endmodule

// File: logic/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  rv_fetch_pkg::inst_u                word,
    input  logic [rv_fetch_pkg::cpu_width-1:0] pc,
    output rv_fetch_pkg::inst_class_t          cls,
    output logic [rv_fetch_pkg::cpu_width-1:0] jal_target
);

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [6:0] funct7_muldiv = 7'd1;

    logic        muldiv;
    logic [20:0] j_imm;

    // M extension lives under OP with funct7 = 1
    assign muldiv = (word.r_view.opcode == op_reg) && (word.r_view.funct7 == funct7_muldiv);

    always_comb begin
        cls           = '0;
        cls.is_mul    = muldiv && (word.r_view.funct3 < 3'd4);
        cls.is_div    = muldiv && (word.r_view.funct3 >= 3'd4);
        cls.is_mem    = (word.i_view.opcode == op_load) || (word.i_view.opcode == op_store);
        cls.is_jal    = (word.i_view.opcode == op_jal);
        cls.is_jalr   = (word.i_view.opcode == op_jalr);
        cls.is_branch = (word.i_view.opcode == op_branch);
    end

    // J immediate is scattered over the I-type imm12, rs1 and funct3 bits
    assign j_imm = {
        word.i_view.imm12[11],
        word.i_view.rs1,
        word.i_view.funct3,
        word.i_view.imm12[0],
        word.i_view.imm12[10:1],
        1'b0
    };

    assign jal_target = pc + {{11{j_imm[20]}}, j_imm};

endmodule

// File: logic/muldiv_hold.sv
`timescale 1ns/1ps

module muldiv_hold (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rv_fetch_pkg::inst_class_t cls,
    input  rv_fetch_pkg::ex_rsp_t     ex_rsp,
    input  logic                      cpu_ready,
    output logic                      hold,
    output logic                      advance
);

    typedef enum logic [1:0] {
        md_idle,
        md_arith,
        md_after,
        md_end
    } md_state_t;

    md_state_t state;
    md_state_t state_nx;
    logic      md_op;
    logic      op_done;

    assign md_op   = cls.is_mul | cls.is_div;
    assign op_done = cls.is_mul ? ex_rsp.mul_done : ex_rsp.div_done;  // only the matching unit

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= md_idle;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            md_idle: begin
                if (cpu_ready && md_op) begin
                    // done can come in the issue cycle itself
                    state_nx = op_done ? md_after : md_arith;
                end
            end
            md_arith: begin
                if (op_done) begin
                    state_nx = md_after;
                end
            end
            md_after: state_nx = md_end;
            md_end:   state_nx = md_idle;
            default:  state_nx = md_idle;
        endcase
    end

    assign hold    = (state == md_arith) || (state == md_after);
    assign advance = (state == md_end);   // one step of +4

endmodule

// File: logic/pc_predict.sv
`timescale 1ns/1ps

module pc_predict #(
    parameter logic [rv_fetch_pkg::cpu_width-1:0] RESET_PC  = 32'h8000_0000,
    parameter int                                 IMEM_ID_W = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  rv_fetch_pkg::inst_class_t            cls,
    input  logic [rv_fetch_pkg::cpu_width-1:0]   jal_target,
    input  rv_fetch_pkg::ex_rsp_t                ex_rsp,
    input  logic                                 cpu_ready,
    output logic [rv_fetch_pkg::cpu_width-1:0]   curr_pc,
    output logic                                 if_valid,
    output logic [IMEM_ID_W-1:0]                 if_send_id
);

    logic                               md_hold;
    logic                               md_advance;
    logic                               jump_pend;
    logic                               jump_dly;
    logic [rv_fetch_pkg::cpu_width-1:0] jump_tgt;
    logic                               jump_open;
    logic                               jump_take;
    logic                               jump_fall;
    logic                               plain_issue;
    logic                               pc_busy;

    // jalr/branch stay open from issue until execute resolves them
    assign jump_open = (cpu_ready & (cls.is_jalr | cls.is_branch)) | jump_pend;
    assign jump_take = jump_open & ex_rsp.jump_valid;
    assign jump_fall = jump_open & cls.is_branch & ex_rsp.wb_res_valid & ~ex_rsp.jump_valid;

    assign plain_issue = cpu_ready &
                         ~(cls.is_mul | cls.is_div | cls.is_jal | cls.is_jalr | cls.is_branch);

    assign pc_busy = md_hold | md_advance | jump_pend | jump_dly;

    fetch_sequencer #(
        .IMEM_ID_W(IMEM_ID_W)
    ) fetch_sequencer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .is_mem    (cls.is_mem),
        .pc_busy   (pc_busy),
        .ex_rsp    (ex_rsp),
        .cpu_ready (cpu_ready),
        .if_valid  (if_valid),
        .if_send_id(if_send_id)
    );

    muldiv_hold muldiv_hold_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cls      (cls),
        .ex_rsp   (ex_rsp),
        .cpu_ready(cpu_ready),
        .hold     (md_hold),
        .advance  (md_advance)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_pend <= 1'b0;
            jump_dly  <= 1'b0;
        end else begin
            jump_pend <= jump_open & ~jump_take & ~jump_fall;
            jump_dly  <= jump_take;   // target goes in one cycle later
        end
    end

    always_ff @(posedge clk) begin
        if (jump_take) begin
            jump_tgt <= ex_rsp.jump_target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= RESET_PC;
        end else if (md_hold) begin
            curr_pc <= curr_pc;   // mul/div still running
        end else if (md_advance || jump_fall) begin
            curr_pc <= curr_pc + 4;
        end else if (jump_dly) begin
            curr_pc <= jump_tgt;
        end else if (cpu_ready && cls.is_jal) begin
            curr_pc <= jal_target;
        end else if (plain_issue) begin
            curr_pc <= curr_pc + 4;
        end
    end

endmodule

// File: logic/rv_fetch_pkg.sv
package rv_fetch_pkg;

    localparam int cpu_width = 32;
    localparam int id_width  = 4;

    typedef logic [id_width-1:0] imem_id_t;

    localparam imem_id_t fetch_id = 4'd1;   // id used by every instruction read

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one fetched word, read as R-type or I-type
    typedef union packed {
        r_type_t r_view;
        i_type_t i_view;
    } inst_u;

    typedef struct packed {
        logic is_mul;
        logic is_div;
        logic is_mem;
        logic is_jal;
        logic is_jalr;
        logic is_branch;
    } inst_class_t;

    typedef struct packed {
        logic                 ar_valid;
        logic [cpu_width-1:0] ar_addr;
        imem_id_t             ar_id;
    } imem_req_t;

    typedef struct packed {
        logic                 r_valid;
        logic [cpu_width-1:0] r_data;
        imem_id_t             r_id;
    } imem_rsp_t;

    typedef struct packed {
        logic                 mul_done;
        logic                 div_done;
        logic                 mem_res_valid;
        logic                 wb_res_valid;
        logic                 w_start;
        logic                 jump_valid;
        logic [cpu_width-1:0] jump_target;
    } ex_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic [cpu_width-1:0] pc;
        inst_u                word;
        inst_class_t          cls;
    } issue_t;

endpackage

// File: logic/rv_fetch_top.sv
`timescale 1ns/1ps

module rv_fetch_top #(
    parameter logic [rv_fetch_pkg::cpu_width-1:0] RESET_PC  = 32'h8000_0000,
    parameter int                                 IMEM_ID_W = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output rv_fetch_pkg::imem_req_t imem_req,
    input  rv_fetch_pkg::imem_rsp_t imem_rsp,
    input  rv_fetch_pkg::ex_rsp_t   ex_rsp,
    output rv_fetch_pkg::issue_t    issue
);

    logic [rv_fetch_pkg::cpu_width-1:0] curr_pc;
    logic [rv_fetch_pkg::cpu_width-1:0] jal_target;
    logic                               if_valid;
    logic [IMEM_ID_W-1:0]               if_send_id;
    logic                               cpu_ready;
    rv_fetch_pkg::inst_u                word;
    rv_fetch_pkg::inst_class_t          cls;

    pc_predict #(
        .RESET_PC (RESET_PC),
        .IMEM_ID_W(IMEM_ID_W)
    ) pc_predict_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cls       (cls),
        .jal_target(jal_target),
        .ex_rsp    (ex_rsp),
        .cpu_ready (cpu_ready),
        .curr_pc   (curr_pc),
        .if_valid  (if_valid),
        .if_send_id(if_send_id)
    );

    imem_read_port #(
        .IMEM_ID_W(IMEM_ID_W)
    ) imem_read_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .if_valid  (if_valid),
        .if_send_id(if_send_id),
        .curr_pc   (curr_pc),
        .imem_req  (imem_req),
        .imem_rsp  (imem_rsp),
        .word      (word),
        .cpu_ready (cpu_ready)
    );

    inst_decode inst_decode_i (
        .word      (word),
        .pc        (curr_pc),
        .cls       (cls),
        .jal_target(jal_target)
    );

    // pc only moves after the issue cycle
    assign issue.valid = cpu_ready;
    assign issue.pc    = curr_pc;
    assign issue.word  = word;
    assign issue.cls   = cls;

endmodule

// File: rv_fetch.f
+incdir+verif
logic/rv_fetch_pkg.sv
logic/fetch_sequencer.sv
logic/muldiv_hold.sv
logic/pc_predict.sv
logic/inst_decode.sv
logic/imem_read_port.sv
logic/rv_fetch_top.sv
verif/rv_fetch_tb.sv

// File: verif/rv_fetch_model.svh
`ifndef RV_FETCH_MODEL_SVH
`define RV_FETCH_MODEL_SVH

localparam int prog_depth = 1024;

int          cur_kind;   // word mix used for newly built words
logic [31:0] prog_word [prog_depth];
logic [31:0] prog_addr [prog_depth];
bit          prog_ok   [prog_depth];

// kind 0 alu, 1 mul/div, 2 load/store, 3 jal, 4 jalr/branch, else all
function automatic logic [31:0] build_word(input int kind);
    logic [31:0] w;
    int          pick;
    w = $urandom;
    case (kind)
        0:       pick = 0;
        1:       pick = $urandom_range(2, 1);
        2:       pick = $urandom_range(4, 3);
        3:       pick = 5;
        4:       pick = $urandom_range(7, 6);
        default: pick = $urandom_range(7, 0);
    endcase
    case (pick)
        0: begin
            w[6:0]   = w[7] ? 7'b0010011 : 7'b0110011;
            w[31:25] = {1'b0, w[30], 5'd0};   // never the M extension
        end
        1, 2: begin
            w[6:0]   = 7'b0110011;
            w[31:25] = 7'd1;
            w[14]    = (pick == 2);           // funct3 >= 4 is divide
        end
        3: w[6:0] = 7'b0000011;
        4: w[6:0] = 7'b0100011;
        5: begin
            w[6:0] = 7'b1101111;
            w[21]  = 1'b0;   // word aligned target
            w[22]  = 1'b1;   // never a jump to itself
        end
        6:       w[6:0] = 7'b1100111;
        default: w[6:0] = 7'b1100011;
    endcase
    return w;
endfunction

function automatic rv_fetch_pkg::inst_class_t class_of(input logic [31:0] w);
    rv_fetch_pkg::inst_class_t c;
    logic                      m_ext;
    m_ext       = (w[6:0] == 7'b0110011) && (w[31:25] == 7'd1);
    c           = '0;
    c.is_mul    = m_ext && (w[14:12] < 3'd4);
    c.is_div    = m_ext && (w[14:12] >= 3'd4);
    c.is_mem    = (w[6:0] == 7'b0000011) || (w[6:0] == 7'b0100011);
    c.is_jal    = (w[6:0] == 7'b1101111);
    c.is_jalr   = (w[6:0] == 7'b1100111);
    c.is_branch = (w[6:0] == 7'b1100011);
    return c;
endfunction

function automatic logic [31:0] jal_offset(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
endfunction

// direct mapped program store, a word is built the first time its address is read
function automatic logic [31:0] word_at(input logic [31:0] addr);
    int idx;
    idx = addr[11:2];
    if (!prog_ok[idx] || prog_addr[idx] != addr) begin
        prog_word[idx] = build_word(cur_kind);
        prog_addr[idx] = addr;
        prog_ok[idx]   = 1'b1;
    end
    return prog_word[idx];
endfunction

`endif

// File: verif/rv_fetch_tb.sv
`timescale 1ns/1ps

module rv_fetch_tb;

    localparam logic [31:0] reset_pc   = 32'h8000_0000;
    localparam int          clk_period = 20;
    localparam int          n_alu      = 50;
    localparam int          n_muldiv   = 40;
    localparam int          n_mem      = 40;
    localparam int          n_jal      = 30;
    localparam int          n_jump     = 40;
    localparam int          n_random   = 400;
    localparam int total_instr = n_alu + n_muldiv + n_mem + n_jal + n_jump + n_random;

    logic                    clk;
    logic                    rst_n;
    rv_fetch_pkg::imem_req_t imem_req;
    rv_fetch_pkg::imem_rsp_t imem_rsp;
    rv_fetch_pkg::ex_rsp_t   ex_rsp;
    rv_fetch_pkg::issue_t    issue;

    logic [31:0] exp_pc;
    int          issue_cnt;
    int          err_cnt;
    int          pass_tests;
    int          fail_tests;
    int          test_num;
    logic        busy;
    logic        fetch_block;   // execute still owes a completion

    `include "rv_fetch_model.svh"

    rv_fetch_top #(
        .RESET_PC (reset_pc),
        .IMEM_ID_W(4)
    ) rv_fetch_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .imem_req(imem_req),
        .imem_rsp(imem_rsp),
        .ex_rsp  (ex_rsp),
        .issue   (issue)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
        err_cnt = err_cnt + 1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // instruction memory serving one read at a time
    task automatic serve_read();
        logic [31:0]            addr;
        rv_fetch_pkg::imem_id_t id;
        int                     delay;
        addr  = imem_req.ar_addr;
        id    = imem_req.ar_id;
        delay = $urandom_range(6, 1);
        if (addr !== exp_pc) begin
            report_mismatch("imem_req.ar_addr", exp_pc, addr);
        end
        if (id !== rv_fetch_pkg::fetch_id) begin
            report_mismatch("imem_req.ar_id", 32'(rv_fetch_pkg::fetch_id), 32'(id));
        end
        for (int i = 1; i < delay; i++) begin
            @(negedge clk);
            imem_rsp.r_valid = (i == 1) && ($urandom_range(3, 0) == 0);   // stray foreign id
            imem_rsp.r_id    = rv_fetch_pkg::fetch_id + 1;
            imem_rsp.r_data  = $urandom;
        end
        @(negedge clk);
        imem_rsp.r_valid = 1'b1;
        imem_rsp.r_id    = id;
        imem_rsp.r_data  = word_at(addr);
        @(negedge clk);
        imem_rsp.r_valid = 1'b0;
    endtask

    // check one issue against the model and play execute
    task automatic execute_issue();
        logic [31:0]               w;
        rv_fetch_pkg::inst_class_t c;
        logic                      taken;
        logic [31:0]               tgt;
        busy = 1'b1;
        w    = word_at(exp_pc);
        c    = class_of(w);
        if (issue.pc !== exp_pc) report_mismatch("issue.pc", exp_pc, issue.pc);
        if (issue.word !== w) report_mismatch("issue.word", w, issue.word);
        if (issue.cls !== c) report_mismatch("issue.cls", c, issue.cls);
        issue_cnt = issue_cnt + 1;
        taken = $urandom_range(1, 0);
        tgt   = reset_pc + ($urandom_range(32'h000f_ffff, 0) << 2);
        if (c.is_jal) begin
            exp_pc = exp_pc + jal_offset(w);
        end else if (c.is_jalr || (c.is_branch && taken)) begin
            exp_pc = tgt;
        end else begin
            exp_pc = exp_pc + 4;
        end
        if (c.is_mul || c.is_div) begin
            fetch_block = 1'b1;
            wait_cycles($urandom_range(5, 0));
            ex_rsp.mul_done = c.is_mul;
            ex_rsp.div_done = c.is_div;
            fetch_block     = 1'b0;
            @(negedge clk);
            ex_rsp.mul_done = 1'b0;
            ex_rsp.div_done = 1'b0;
        end else if (c.is_mem) begin
            fetch_block = 1'b1;
            wait_cycles($urandom_range(5, 0));
            ex_rsp.mem_res_valid = 1'b1;
            @(negedge clk);
            ex_rsp.mem_res_valid = 1'b0;
            wait_cycles($urandom_range(4, 0));
            ex_rsp.wb_res_valid = 1'b1;
            fetch_block         = 1'b0;
            @(negedge clk);
            ex_rsp.wb_res_valid = 1'b0;
        end else if (c.is_jalr || c.is_branch) begin
            fetch_block = 1'b1;
            wait_cycles($urandom_range(5, 0));
            if (c.is_jalr || taken) begin
                ex_rsp.jump_valid  = 1'b1;
                ex_rsp.jump_target = tgt;
            end else begin
                ex_rsp.wb_res_valid = 1'b1;   // untaken branch
            end
            fetch_block = 1'b0;
            @(negedge clk);
            ex_rsp.jump_valid   = 1'b0;
            ex_rsp.wb_res_valid = 1'b0;
        end
        busy = 1'b0;
    endtask

    task automatic run_test(input string name, input int kind, input int count);
        int err_start;
        int target;
        err_start = err_cnt;
        cur_kind  = kind;
        target    = issue_cnt + count;
        test_num  = test_num + 1;
        while (issue_cnt < target) begin
            @(negedge clk);
        end
        wait (!busy);
        if (err_cnt == err_start) begin
            pass_tests = pass_tests + 1;
            $display("test %0d %s: pass, %0d instructions", test_num, name, count);
        end else begin
            fail_tests = fail_tests + 1;
            $display("test %0d %s: fail, %0d errors", test_num, name, err_cnt - err_start);
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && imem_req.ar_valid) serve_read();
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && issue.valid) execute_issue();
        end
    end

    always @(posedge clk) begin
        if (rst_n && imem_req.ar_valid && fetch_block) begin
            $display("fetch issued at %0t ns before execute completed the instruction", $time);
            err_cnt = err_cnt + 1;
        end
    end

    initial begin
        #(total_instr * 40 * clk_period);
        $display("watchdog: run stalled after %0d of %0d issues", issue_cnt, total_instr);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(95));
        rst_n       = 1'b0;
        imem_rsp    = '0;
        ex_rsp      = '0;
        exp_pc      = reset_pc;
        issue_cnt   = 0;
        err_cnt     = 0;
        pass_tests  = 0;
        fail_tests  = 0;
        test_num    = 0;
        busy        = 1'b0;
        fetch_block = 1'b0;
        cur_kind    = 0;
        repeat (5) @(negedge clk);
        if (rv_fetch_top_i.curr_pc !== reset_pc) begin
            report_mismatch("curr_pc", reset_pc, rv_fetch_top_i.curr_pc);
        end
        if (rv_fetch_top_i.if_valid !== 1'b0) begin
            report_mismatch("if_valid", 0, rv_fetch_top_i.if_valid);
        end
        if (imem_req.ar_valid !== 1'b0) begin
            report_mismatch("imem_req.ar_valid", 0, imem_req.ar_valid);
        end
        if (issue.valid !== 1'b0) report_mismatch("issue.valid", 0, issue.valid);
        rst_n = 1'b1;

        run_test("plain alu stream", 0, n_alu);
        run_test("mul/div hold", 1, n_muldiv);
        run_test("load/store phases", 2, n_mem);
        run_test("jal targets", 3, n_jal);
        run_test("jalr and branches", 4, n_jump);
        run_test("random mix", 5, n_random);

        $display("tests passed: %0d, failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
